//--- compile.f
+incdir+logic
logic/coll_pkg.sv
logic/comm_table.sv
logic/reduce_unit.sv
logic/bcast_unit.sv
logic/coll_router.sv
logic/network.sv
tb/network_tb.sv

//--- logic/bcast_unit.sv
`include "coll_params.svh"

module bcast_unit (
	input  logic                clk,
	input  logic                rst,
	input  coll_pkg::flit_t     root_flit,
	input  coll_pkg::flit_t     parent_flit,
	input  coll_pkg::dir_mask_t child_mask_root,
	input  coll_pkg::dir_mask_t child_mask_parent,
	output coll_pkg::flit_t     out_flit [`COLL_NUM_DIRS],
	output coll_pkg::flit_t     deliver
);

	coll_pkg::flit_t     sel_flit;
	coll_pkg::dir_mask_t sel_mask;
	// Registered copy of the chosen flit
	coll_pkg::flit_t     bc_r;
	logic [`COLL_NUM_DIRS-1:0] out_vld;
	logic                dlv_vld;

	// Root result wins over a parent broadcast
	always_comb begin
		if (root_flit.valid) begin
			sel_flit = root_flit;
			sel_mask = child_mask_root;
		end else begin
			sel_flit = parent_flit;
			sel_mask = child_mask_parent;
		end
		// Whatever went in, it leaves as final result
		sel_flit.kind = coll_pkg::bcast;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_vld <= '0;
			dlv_vld <= 1'b0;
		end else begin
			out_vld <= sel_mask & {`COLL_NUM_DIRS{sel_flit.valid}};
			dlv_vld <= sel_flit.valid;
		end
		bc_r <= sel_flit;
	end

	//////////////////////////////
	// Fan-out to children and local delivery

	always_comb begin
		for (int d = 0; d < `COLL_NUM_DIRS; d++) begin
			out_flit[d]       = bc_r;
			out_flit[d].valid = out_vld[d];
		end
		deliver       = bc_r;
		deliver.valid = dlv_vld;
	end

	// Root completion and a parent broadcast never coincide
	a_one_source: assert property (@(posedge clk) disable iff (rst)
		!(root_flit.valid && parent_flit.valid));

endmodule

//--- logic/coll_params.svh
`ifndef COLL_PARAMS_SVH
`define COLL_PARAMS_SVH

//////////////////////////////
// Bit widths of the two strobe words

// Collective flit
`define COLL_FLIT_W 85
// Newcomm registration word
`define COLL_COMM_W 61
// Reduction operand and result
`define COLL_PAYLOAD_W 64

//////////////////////////////
// Router shape

// xpos, ypos, zpos, xneg, yneg, zneg
`define COLL_NUM_DIRS 6
// Communicators held per node
`define COLL_COMM_ENTRIES 4
`define COLL_SLOT_W 2

`endif

//--- logic/coll_pkg.sv
`include "coll_params.svh"

package coll_pkg;

	// Field types shared by flits and table entries
	typedef logic [7:0] comm_id_t;
	typedef logic [`COLL_PAYLOAD_W-1:0] payload_t;
	typedef logic [`COLL_NUM_DIRS-1:0] dir_mask_t;
	// Seq takes what the flit has left after valid, kind, comm_id and payload
	typedef logic [`COLL_FLIT_W-`COLL_PAYLOAD_W-12:0] seq_t;

	// Port directions, also the bit index of a child mask
	typedef enum logic [2:0] {
		xpos     = 3'd0,
		ypos     = 3'd1,
		zpos     = 3'd2,
		xneg     = 3'd3,
		yneg     = 3'd4,
		zneg     = 3'd5,
		dir_root = 3'd7
	} dir_e;

	// Contribution or partial result vs. final result
	typedef enum logic [1:0] {
		none   = 2'd0,
		reduce = 2'd1,
		bcast  = 2'd2
	} kind_e;

	// Max and min compare unsigned, sum wraps
	typedef enum logic [1:0] {
		sum     = 2'd0,
		max     = 2'd1,
		min     = 2'd2,
		bit_and = 2'd3
	} op_e;

	typedef struct packed {
		logic     valid;
		kind_e    kind;
		comm_id_t comm_id;
		seq_t     seq;
		payload_t payload;
	} flit_t;

	// Node position, carried along but not acted on
	typedef struct packed {
		logic [2:0] x;
		logic [2:0] y;
		logic [2:0] z;
	} coord_t;

	typedef struct packed {
		logic                     valid;
		comm_id_t                 comm_id;
		coord_t                   coord;
		dir_mask_t                child_mask;
		dir_e                     parent;
		op_e                      op;
		logic [`COLL_COMM_W-30:0] reserved;
	} newcomm_t;

	// What a node keeps of a registered communicator
	typedef struct packed {
		logic      valid;
		comm_id_t  comm_id;
		dir_mask_t child_mask;
		dir_e      parent;
		op_e       op;
	} comm_entry_t;

endpackage

//--- logic/coll_router.sv
`include "coll_params.svh"

module coll_router (
	input  logic               clk,
	input  logic               rst,
	input  coll_pkg::flit_t    in_flit [`COLL_NUM_DIRS],
	input  coll_pkg::newcomm_t newcomm,
	output coll_pkg::flit_t    out_flit [`COLL_NUM_DIRS],
	output coll_pkg::flit_t    deliver
);

	coll_pkg::flit_t               in_r      [`COLL_NUM_DIRS];
	coll_pkg::comm_id_t            lookup_id [`COLL_NUM_DIRS];
	logic                          hit       [`COLL_NUM_DIRS];
	logic [`COLL_SLOT_W-1:0]       slot      [`COLL_NUM_DIRS];
	coll_pkg::comm_entry_t         entries   [`COLL_COMM_ENTRIES];
	logic [`COLL_COMM_ENTRIES-1:0] cleared;
	logic                          red_take  [`COLL_NUM_DIRS];
	coll_pkg::flit_t               res_flit;
	logic [`COLL_SLOT_W-1:0]       res_slot;
	logic                          res_root;
	coll_pkg::flit_t               root_flit;
	coll_pkg::flit_t               par_flit;
	coll_pkg::dir_mask_t           par_mask;
	coll_pkg::flit_t               bc_out    [`COLL_NUM_DIRS];
	logic [`COLL_NUM_DIRS-1:0]     up_sel;

	//////////////////////////////
	// Input stage

	always_ff @(posedge clk) begin
		for (int d = 0; d < `COLL_NUM_DIRS; d++) begin
			if (rst) begin
				in_r[d].valid <= 1'b0;
			end else begin
				in_r[d].valid <= in_flit[d].valid;
			end
			in_r[d].kind    <= in_flit[d].kind;
			in_r[d].comm_id <= in_flit[d].comm_id;
			in_r[d].seq     <= in_flit[d].seq;
			in_r[d].payload <= in_flit[d].payload;
		end
	end

	always_comb begin
		for (int d = 0; d < `COLL_NUM_DIRS; d++) begin
			lookup_id[d] = in_r[d].comm_id;
		end
	end

	comm_table u_table (
		.clk       (clk),
		.rst       (rst),
		.newcomm   (newcomm),
		.lookup_id (lookup_id),
		.hit       (hit),
		.slot      (slot),
		.entries   (entries),
		.cleared   (cleared)
	);

	// Reduce only from children, broadcast only from the parent
	always_comb begin
		par_flit = '0;
		par_mask = '0;
		for (int d = `COLL_NUM_DIRS - 1; d >= 0; d--) begin
			red_take[d] = in_r[d].valid && hit[d] && in_r[d].kind == coll_pkg::reduce
				&& entries[slot[d]].child_mask[d];
			// Lowest port wins if several parents fire at once
			if (in_r[d].valid && hit[d] && in_r[d].kind == coll_pkg::bcast
					&& int'(entries[slot[d]].parent) == d) begin
				par_flit = in_r[d];
				par_mask = entries[slot[d]].child_mask;
			end
		end
	end

	reduce_unit u_reduce (
		.clk      (clk),
		.rst      (rst),
		.in_flit  (in_r),
		.in_take  (red_take),
		.in_slot  (slot),
		.entries  (entries),
		.cleared  (cleared),
		.res_flit (res_flit),
		.res_slot (res_slot),
		.res_root (res_root)
	);

	// Root results turn around into a broadcast
	always_comb begin
		root_flit       = res_flit;
		root_flit.valid = res_flit.valid && res_root;
	end

	bcast_unit u_bcast (
		.clk               (clk),
		.rst               (rst),
		.root_flit         (root_flit),
		.parent_flit       (par_flit),
		.child_mask_root   (entries[res_slot].child_mask),
		.child_mask_parent (par_mask),
		.out_flit          (bc_out),
		.deliver           (deliver)
	);

	//////////////////////////////
	// Output merge

	always_comb begin
		for (int d = 0; d < `COLL_NUM_DIRS; d++) begin
			// Partial result heads up toward the parent
			up_sel[d] = res_flit.valid && !res_root
				&& int'(entries[res_slot].parent) == d;
			out_flit[d] = up_sel[d] ? res_flit : bc_out[d];
		end
	end

endmodule

//--- logic/comm_table.sv
`include "coll_params.svh"

module comm_table (
	input  logic                          clk,
	input  logic                          rst,
	input  coll_pkg::newcomm_t            newcomm,
	input  coll_pkg::comm_id_t            lookup_id [`COLL_NUM_DIRS],
	output logic                          hit [`COLL_NUM_DIRS],
	output logic [`COLL_SLOT_W-1:0]       slot [`COLL_NUM_DIRS],
	output coll_pkg::comm_entry_t         entries [`COLL_COMM_ENTRIES],
	output logic [`COLL_COMM_ENTRIES-1:0] cleared
);

	logic                    match_found;
	logic [`COLL_SLOT_W-1:0] match_slot;
	logic                    free_found;
	logic [`COLL_SLOT_W-1:0] free_slot;
	logic                    wr_en;
	logic [`COLL_SLOT_W-1:0] wr_slot;

	//////////////////////////////
	// Where a newcomm lands

	always_comb begin
		match_found = 1'b0;
		match_slot  = '0;
		free_found  = 1'b0;
		free_slot   = '0;
		// Walk down so the lowest hit is the one kept
		for (int i = `COLL_COMM_ENTRIES - 1; i >= 0; i--) begin
			if (entries[i].valid && entries[i].comm_id == newcomm.comm_id) begin
				match_found = 1'b1;
				match_slot  = i[`COLL_SLOT_W-1:0];
			end
			if (!entries[i].valid) begin
				free_found = 1'b1;
				free_slot  = i[`COLL_SLOT_W-1:0];
			end
		end
	end

	// Same comm_id overwrites, else first empty slot; table full drops it
	assign wr_en   = newcomm.valid && (match_found || free_found);
	assign wr_slot = match_found ? match_slot : free_slot;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `COLL_COMM_ENTRIES; i++) begin
				entries[i].valid <= 1'b0;
			end
			cleared <= '0;
		end else begin
			cleared <= '0;
			if (wr_en) begin
				entries[wr_slot] <= '{
					valid:      1'b1,
					comm_id:    newcomm.comm_id,
					child_mask: newcomm.child_mask,
					parent:     newcomm.parent,
					op:         newcomm.op
				};
				// Tell the reduce side to drop partial state
				cleared[wr_slot] <= 1'b1;
			end
		end
	end

	//////////////////////////////
	// Lookup, one per input port

	always_comb begin
		for (int d = 0; d < `COLL_NUM_DIRS; d++) begin
			hit[d]  = 1'b0;
			slot[d] = '0;
			for (int i = `COLL_COMM_ENTRIES - 1; i >= 0; i--) begin
				if (entries[i].valid && entries[i].comm_id == lookup_id[d]) begin
					hit[d]  = 1'b1;
					slot[d] = i[`COLL_SLOT_W-1:0];
				end
			end
		end
	end

	// Reserved field must come in as zero
	a_newcomm_reserved: assert property (@(posedge clk) disable iff (rst)
		newcomm.valid |-> newcomm.reserved == '0);

endmodule

//--- logic/network.sv
`include "coll_params.svh"

module network (
	input  logic               clk,
	input  logic               rst,
	input  coll_pkg::flit_t    in_xpos_inject_0_0_0,
	input  coll_pkg::flit_t    in_ypos_inject_0_0_0,
	input  coll_pkg::flit_t    in_zpos_inject_0_0_0,
	input  coll_pkg::flit_t    in_xneg_inject_0_0_0,
	input  coll_pkg::flit_t    in_yneg_inject_0_0_0,
	input  coll_pkg::flit_t    in_zneg_inject_0_0_0,
	input  coll_pkg::newcomm_t newcomm_0_0_0,
	input  coll_pkg::flit_t    in_xpos_inject_0_0_1,
	input  coll_pkg::flit_t    in_ypos_inject_0_0_1,
	input  coll_pkg::flit_t    in_zpos_inject_0_0_1,
	input  coll_pkg::flit_t    in_xneg_inject_0_0_1,
	input  coll_pkg::flit_t    in_yneg_inject_0_0_1,
	input  coll_pkg::flit_t    in_zneg_inject_0_0_1,
	input  coll_pkg::newcomm_t newcomm_0_0_1,
	output coll_pkg::flit_t    out_xpos_0_0_0,
	output coll_pkg::flit_t    out_ypos_0_0_0,
	output coll_pkg::flit_t    out_xneg_0_0_0,
	output coll_pkg::flit_t    out_yneg_0_0_0,
	output coll_pkg::flit_t    out_zneg_0_0_0,
	output coll_pkg::flit_t    out_xpos_0_0_1,
	output coll_pkg::flit_t    out_ypos_0_0_1,
	output coll_pkg::flit_t    out_zpos_0_0_1,
	output coll_pkg::flit_t    out_xneg_0_0_1,
	output coll_pkg::flit_t    out_yneg_0_0_1,
	output coll_pkg::flit_t    deliver_0_0_0,
	output coll_pkg::flit_t    deliver_0_0_1,
	output logic               valid
);

	coll_pkg::flit_t in_0  [`COLL_NUM_DIRS];
	coll_pkg::flit_t in_1  [`COLL_NUM_DIRS];
	coll_pkg::flit_t out_0 [`COLL_NUM_DIRS];
	coll_pkg::flit_t out_1 [`COLL_NUM_DIRS];

	//////////////////////////////
	// Node inputs, z link merged in

	assign in_0[coll_pkg::xpos] = in_xpos_inject_0_0_0;
	assign in_0[coll_pkg::ypos] = in_ypos_inject_0_0_0;
	// Link flit beats the external one
	assign in_0[coll_pkg::zpos] = out_1[coll_pkg::zneg].valid ? out_1[coll_pkg::zneg]
		: in_zpos_inject_0_0_0;
	assign in_0[coll_pkg::xneg] = in_xneg_inject_0_0_0;
	assign in_0[coll_pkg::yneg] = in_yneg_inject_0_0_0;
	assign in_0[coll_pkg::zneg] = in_zneg_inject_0_0_0;

	assign in_1[coll_pkg::xpos] = in_xpos_inject_0_0_1;
	assign in_1[coll_pkg::ypos] = in_ypos_inject_0_0_1;
	assign in_1[coll_pkg::zpos] = in_zpos_inject_0_0_1;
	assign in_1[coll_pkg::xneg] = in_xneg_inject_0_0_1;
	assign in_1[coll_pkg::yneg] = in_yneg_inject_0_0_1;
	assign in_1[coll_pkg::zneg] = out_0[coll_pkg::zpos].valid ? out_0[coll_pkg::zpos]
		: in_zneg_inject_0_0_1;

	coll_router u_node_0_0_0 (
		.clk      (clk),
		.rst      (rst),
		.in_flit  (in_0),
		.newcomm  (newcomm_0_0_0),
		.out_flit (out_0),
		.deliver  (deliver_0_0_0)
	);

	coll_router u_node_0_0_1 (
		.clk      (clk),
		.rst      (rst),
		.in_flit  (in_1),
		.newcomm  (newcomm_0_0_1),
		.out_flit (out_1),
		.deliver  (deliver_0_0_1)
	);

	//////////////////////////////
	// Outputs toward the outside neighbours

	assign out_xpos_0_0_0 = out_0[coll_pkg::xpos];
	assign out_ypos_0_0_0 = out_0[coll_pkg::ypos];
	assign out_xneg_0_0_0 = out_0[coll_pkg::xneg];
	assign out_yneg_0_0_0 = out_0[coll_pkg::yneg];
	assign out_zneg_0_0_0 = out_0[coll_pkg::zneg];
	assign out_xpos_0_0_1 = out_1[coll_pkg::xpos];
	assign out_ypos_0_0_1 = out_1[coll_pkg::ypos];
	assign out_zpos_0_0_1 = out_1[coll_pkg::zpos];
	assign out_xneg_0_0_1 = out_1[coll_pkg::xneg];
	assign out_yneg_0_0_1 = out_1[coll_pkg::yneg];

	// Any local delivery in this cycle
	assign valid = deliver_0_0_0.valid | deliver_0_0_1.valid;

endmodule

//--- logic/reduce_unit.sv
`include "coll_params.svh"

module reduce_unit (
	input  logic                          clk,
	input  logic                          rst,
	input  coll_pkg::flit_t               in_flit [`COLL_NUM_DIRS],
	input  logic                          in_take [`COLL_NUM_DIRS],
	input  logic [`COLL_SLOT_W-1:0]       in_slot [`COLL_NUM_DIRS],
	input  coll_pkg::comm_entry_t         entries [`COLL_COMM_ENTRIES],
	input  logic [`COLL_COMM_ENTRIES-1:0] cleared,
	output coll_pkg::flit_t               res_flit,
	output logic [`COLL_SLOT_W-1:0]       res_slot,
	output logic                          res_root
);

	// Per-slot state
	coll_pkg::payload_t  acc         [`COLL_COMM_ENTRIES];
	coll_pkg::dir_mask_t arrived     [`COLL_COMM_ENTRIES];
	coll_pkg::seq_t      seq_r       [`COLL_COMM_ENTRIES];
	coll_pkg::payload_t  acc_nxt     [`COLL_COMM_ENTRIES];
	coll_pkg::dir_mask_t arrived_nxt [`COLL_COMM_ENTRIES];
	coll_pkg::seq_t      seq_nxt     [`COLL_COMM_ENTRIES];

	logic [`COLL_COMM_ENTRIES-1:0] complete;
	logic                          emit_valid;
	logic [`COLL_SLOT_W-1:0]       emit_slot;

	function automatic coll_pkg::payload_t apply_op(
		input coll_pkg::op_e      op,
		input coll_pkg::payload_t a,
		input coll_pkg::payload_t b
	);
		case (op)
			coll_pkg::sum: return a + b;
			coll_pkg::max: return (a > b) ? a : b;
			coll_pkg::min: return (a < b) ? a : b;
			default:       return a & b;
		endcase
	endfunction

	//////////////////////////////
	// Completion, lowest slot first

	always_comb begin
		for (int s = 0; s < `COLL_COMM_ENTRIES; s++) begin
			complete[s] = entries[s].valid && arrived[s] != '0
				&& arrived[s] == entries[s].child_mask;
		end
		emit_valid = |complete;
		emit_slot  = '0;
		for (int s = `COLL_COMM_ENTRIES - 1; s >= 0; s--) begin
			if (complete[s]) begin
				emit_slot = s[`COLL_SLOT_W-1:0];
			end
		end
	end

	//////////////////////////////
	// Fold this cycle's contributions

	always_comb begin
		for (int s = 0; s < `COLL_COMM_ENTRIES; s++) begin
			// Fresh start on newcomm or on the slot being emitted
			if (cleared[s] || (emit_valid && emit_slot == s)) begin
				acc_nxt[s]     = '0;
				arrived_nxt[s] = '0;
				seq_nxt[s]     = '0;
			end else begin
				acc_nxt[s]     = acc[s];
				arrived_nxt[s] = arrived[s];
				seq_nxt[s]     = seq_r[s];
			end
			for (int d = 0; d < `COLL_NUM_DIRS; d++) begin
				if (in_take[d] && in_slot[d] == s) begin
					// First arrival opens the instance
					if (arrived_nxt[s] == '0) begin
						acc_nxt[s] = in_flit[d].payload;
						seq_nxt[s] = in_flit[d].seq;
					end else begin
						acc_nxt[s] = apply_op(entries[s].op, acc_nxt[s], in_flit[d].payload);
					end
					arrived_nxt[s][d] = 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < `COLL_COMM_ENTRIES; s++) begin
				acc[s]     <= '0;
				arrived[s] <= '0;
				seq_r[s]   <= '0;
			end
			res_flit.valid <= 1'b0;
			res_root       <= 1'b0;
		end else begin
			acc            <= acc_nxt;
			arrived        <= arrived_nxt;
			seq_r          <= seq_nxt;
			res_flit.valid <= emit_valid;
			res_root       <= emit_valid && entries[emit_slot].parent == coll_pkg::dir_root;
		end
		// Result body, only meaningful with valid
		res_flit.kind    <= coll_pkg::reduce;
		res_flit.comm_id <= entries[emit_slot].comm_id;
		res_flit.seq     <= seq_r[emit_slot];
		res_flit.payload <= acc[emit_slot];
		res_slot         <= emit_slot;
	end

	//////////////////////////////
	// Per-port contribution checks

	for (genvar d = 0; d < `COLL_NUM_DIRS; d++) begin : g_chk
		// One contribution per child per instance
		a_no_repeat: assert property (@(posedge clk) disable iff (rst)
			in_take[d] && !cleared[in_slot[d]] && !complete[in_slot[d]]
				|-> !arrived[in_slot[d]][d]);
		// Later children belong to the instance already open
		a_seq_match: assert property (@(posedge clk) disable iff (rst)
			in_take[d] && !cleared[in_slot[d]] && !complete[in_slot[d]]
				&& arrived[in_slot[d]] != '0 |-> in_flit[d].seq == seq_r[in_slot[d]]);
	end

endmodule

//--- tb/network_tb.sv
`include "coll_params.svh"

module network_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int num_tests = 6;
	localparam int num_ports = 12;
	// Watchdog budget, 40 cycles per test plus slack
	localparam int timeout_ns = (num_tests * 40 + 20) * 100;
	// Drive-to-sample latencies, the sampling edge adds one
	localparam int lat_root = 5;
	localparam int lat_far_root = 8;
	localparam int lat_far_leaf = 10;
	// Longest path is under this many cycles
	localparam int quiet_cycles = 12;

	logic               clk;
	logic               rst;
	coll_pkg::flit_t    inj0 [`COLL_NUM_DIRS];
	coll_pkg::flit_t    inj1 [`COLL_NUM_DIRS];
	coll_pkg::newcomm_t nc0;
	coll_pkg::newcomm_t nc1;
	// 0 deliver, 1-5 outputs of node 0_0_0; 6 deliver, 7-11 outputs of node 0_0_1
	coll_pkg::flit_t    obs [num_ports];
	logic               top_valid;
	int                 cyc;

	// Expected flits, three queues kept in step
	int                 exp_port [$];
	int                 exp_cyc  [$];
	coll_pkg::flit_t    exp_flit [$];

	network u_dut (
		.clk                  (clk),
		.rst                  (rst),
		.in_xpos_inject_0_0_0 (inj0[coll_pkg::xpos]),
		.in_ypos_inject_0_0_0 (inj0[coll_pkg::ypos]),
		.in_zpos_inject_0_0_0 (inj0[coll_pkg::zpos]),
		.in_xneg_inject_0_0_0 (inj0[coll_pkg::xneg]),
		.in_yneg_inject_0_0_0 (inj0[coll_pkg::yneg]),
		.in_zneg_inject_0_0_0 (inj0[coll_pkg::zneg]),
		.newcomm_0_0_0        (nc0),
		.in_xpos_inject_0_0_1 (inj1[coll_pkg::xpos]),
		.in_ypos_inject_0_0_1 (inj1[coll_pkg::ypos]),
		.in_zpos_inject_0_0_1 (inj1[coll_pkg::zpos]),
		.in_xneg_inject_0_0_1 (inj1[coll_pkg::xneg]),
		.in_yneg_inject_0_0_1 (inj1[coll_pkg::yneg]),
		.in_zneg_inject_0_0_1 (inj1[coll_pkg::zneg]),
		.newcomm_0_0_1        (nc1),
		.out_xpos_0_0_0       (obs[1]),
		.out_ypos_0_0_0       (obs[2]),
		.out_xneg_0_0_0       (obs[3]),
		.out_yneg_0_0_0       (obs[4]),
		.out_zneg_0_0_0       (obs[5]),
		.out_xpos_0_0_1       (obs[7]),
		.out_ypos_0_0_1       (obs[8]),
		.out_zpos_0_0_1       (obs[9]),
		.out_xneg_0_0_1       (obs[10]),
		.out_yneg_0_0_1       (obs[11]),
		.deliver_0_0_0        (obs[0]),
		.deliver_0_0_1        (obs[6]),
		.valid                (top_valid)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	//////////////////////////////
	// Reference model

	// Fold n values left to right with the communicator's operator
	function automatic coll_pkg::payload_t ref_reduce(input coll_pkg::op_e op,
		input coll_pkg::payload_t vals [4], input int n);
		coll_pkg::payload_t r;
		r = vals[0];
		for (int i = 1; i < n; i++) begin
			case (op)
				coll_pkg::sum: r = r + vals[i];
				coll_pkg::max: r = (vals[i] > r) ? vals[i] : r;
				coll_pkg::min: r = (vals[i] < r) ? vals[i] : r;
				default:       r = r & vals[i];
			endcase
		end
		return r;
	endfunction

	// Observed port of a node's output toward dir, -1 on the z link
	function automatic int port_of(input int node, input coll_pkg::dir_e dir);
		int base;
		base = node * 6;
		case (dir)
			coll_pkg::xpos: return base + 1;
			coll_pkg::ypos: return base + 2;
			coll_pkg::zpos: return (node == 0) ? -1 : base + 3;
			coll_pkg::xneg: return (node == 0) ? base + 3 : base + 4;
			coll_pkg::yneg: return (node == 0) ? base + 4 : base + 5;
			coll_pkg::zneg: return (node == 0) ? base + 5 : -1;
			default:        return -1;
		endcase
	endfunction

	// Final result on deliver and on every visible child port
	task automatic expect_result(input int node, input coll_pkg::dir_mask_t children,
		input int at, input coll_pkg::comm_id_t id, input coll_pkg::seq_t seq,
		input coll_pkg::payload_t pl);
		coll_pkg::flit_t f;
		int p;
		f = '{valid: 1'b1, kind: coll_pkg::bcast, comm_id: id, seq: seq, payload: pl};
		exp_port.push_back(node * 6);
		exp_cyc.push_back(at);
		exp_flit.push_back(f);
		for (int d = 0; d < `COLL_NUM_DIRS; d++) begin
			p = port_of(node, coll_pkg::dir_e'(d));
			if (children[d] && p >= 0) begin
				exp_port.push_back(p);
				exp_cyc.push_back(at);
				exp_flit.push_back(f);
			end
		end
	endtask

	function automatic int find_exp(input int port, input int at);
		for (int i = 0; i < exp_port.size(); i++) begin
			if (exp_port[i] == port && exp_cyc[i] == at) begin
				return i;
			end
		end
		return -1;
	endfunction

	task automatic report_error(input string msg);
		$display("FAILED at %0d ns: %s", $time, msg);
		$display("Some tests failed");
		$fatal(1, "stopping at the first error");
	endtask

	//////////////////////////////
	// Compare on every rising edge

	always @(posedge clk) begin
		int   idx;
		logic dlv_due;
		cyc = cyc + 1;
		if (!rst) begin
			dlv_due = 1'b0;
			for (int p = 0; p < num_ports; p++) begin
				idx = find_exp(p, cyc);
				if (idx >= 0 && (p == 0 || p == 6)) begin
					dlv_due = 1'b1;
				end
				if (obs[p].valid) begin
					assert (idx >= 0)
					else report_error($sformatf("unexpected flit %h on port %0d", obs[p], p));
					if (idx >= 0) begin
						assert (obs[p] == exp_flit[idx])
						else report_error($sformatf("port %0d got %h, expected %h",
							p, obs[p], exp_flit[idx]));
						exp_port.delete(idx);
						exp_cyc.delete(idx);
						exp_flit.delete(idx);
					end
				end else begin
					assert (idx < 0)
					else report_error($sformatf("port %0d missed %h", p, exp_flit[idx]));
				end
			end
			// Top valid follows local delivery only
			assert (top_valid == dlv_due)
			else report_error($sformatf("top valid is %b, expected %b", top_valid, dlv_due));
		end
	end

	//////////////////////////////
	// Stimulus helpers

	// Next falling edge, all strobes back to idle
	task automatic next_cycle();
		@(negedge clk);
		for (int d = 0; d < `COLL_NUM_DIRS; d++) begin
			inj0[d] = '0;
			inj1[d] = '0;
		end
		nc0 = '0;
		nc1 = '0;
	endtask

	task automatic send(input int node, input coll_pkg::dir_e dir, input coll_pkg::kind_e kind,
		input coll_pkg::comm_id_t id, input coll_pkg::seq_t seq, input coll_pkg::payload_t pl);
		coll_pkg::flit_t f;
		f = '{valid: 1'b1, kind: kind, comm_id: id, seq: seq, payload: pl};
		if (node == 0) begin
			inj0[dir] = f;
		end else begin
			inj1[dir] = f;
		end
	endtask

	task automatic register_comm(input int node, input coll_pkg::comm_id_t id,
		input coll_pkg::dir_mask_t children, input coll_pkg::dir_e parent,
		input coll_pkg::op_e op);
		coll_pkg::newcomm_t n;
		n = '0;
		n.valid = 1'b1;
		n.comm_id = id;
		n.coord.z = (node == 0) ? 3'd0 : 3'd1;
		n.child_mask = children;
		n.parent = parent;
		n.op = op;
		if (node == 0) begin
			nc0 = n;
		end else begin
			nc1 = n;
		end
	endtask

	function automatic coll_pkg::payload_t rand_payload();
		return {$urandom(), $urandom()};
	endfunction

	task automatic wait_drain();
		while (exp_port.size() != 0) begin
			next_cycle();
		end
		repeat (2) next_cycle();
	endtask

	//////////////////////////////
	// Tests

	// Root at 0_0_0, children xpos and ypos, sum wraps
	task automatic test_single_sum();
		coll_pkg::payload_t v [4];
		v[0] = 64'hffff_ffff_ffff_fff0;
		v[1] = 64'h0000_0000_0000_0025;
		next_cycle();
		register_comm(0, 8'd10, 6'b000011, coll_pkg::dir_root, coll_pkg::sum);
		next_cycle();
		send(0, coll_pkg::xpos, coll_pkg::reduce, 8'd10, 10'd1, v[0]);
		repeat (2) next_cycle();
		send(0, coll_pkg::ypos, coll_pkg::reduce, 8'd10, 10'd1, v[1]);
		expect_result(0, 6'b000011, cyc + lat_root, 8'd10, 10'd1,
			ref_reduce(coll_pkg::sum, v, 2));
		wait_drain();
	endtask

	// Leaf 0_0_1 under root 0_0_0 across z; ext drives 0_0_0 zpos with the link busy
	task automatic run_two_node(input coll_pkg::seq_t seq, input logic ext_collide);
		coll_pkg::payload_t v [4];
		coll_pkg::payload_t res;
		v[0] = rand_payload();
		v[1] = rand_payload();
		res = ref_reduce(coll_pkg::sum, v, 2);
		send(0, coll_pkg::xneg, coll_pkg::reduce, 8'd20, seq, v[0]);
		next_cycle();
		send(1, coll_pkg::xpos, coll_pkg::reduce, 8'd20, seq, v[1]);
		expect_result(0, 6'b001100, cyc + lat_far_root, 8'd20, seq, res);
		expect_result(1, 6'b000001, cyc + lat_far_leaf, 8'd20, seq, res);
		if (ext_collide) begin
			// Partial result sits on the link in this cycle
			repeat (3) next_cycle();
			send(0, coll_pkg::zpos, coll_pkg::reduce, 8'd20, seq, rand_payload());
		end
		wait_drain();
	endtask

	// Three operators, each a root at 0_0_1 with three children
	task automatic test_operators();
		coll_pkg::payload_t v [4];
		coll_pkg::op_e op;
		for (int i = 0; i < 3; i++) begin
			next_cycle();
			register_comm(1, 8'd31 + i[7:0], 6'b010011, coll_pkg::dir_root,
				coll_pkg::op_e'(i + 1));
		end
		for (int i = 0; i < 3; i++) begin
			op = coll_pkg::op_e'(i + 1);
			for (coll_pkg::seq_t r = 10'd1; r <= 10'd2; r++) begin
				for (int j = 0; j < 3; j++) begin
					v[j] = rand_payload();
				end
				next_cycle();
				send(1, coll_pkg::xpos, coll_pkg::reduce, 8'd31 + i[7:0], r, v[0]);
				send(1, coll_pkg::ypos, coll_pkg::reduce, 8'd31 + i[7:0], r, v[1]);
				next_cycle();
				send(1, coll_pkg::yneg, coll_pkg::reduce, 8'd31 + i[7:0], r, v[2]);
				expect_result(1, 6'b010011, cyc + lat_root, 8'd31 + i[7:0], r,
					ref_reduce(op, v, 3));
				wait_drain();
			end
		end
	endtask

	// Comm 40 sum over xpos, ypos; comm 41 max over ypos, yneg
	task automatic test_concurrent();
		coll_pkg::payload_t a [4];
		coll_pkg::payload_t b [4];
		next_cycle();
		register_comm(0, 8'd40, 6'b000011, coll_pkg::dir_root, coll_pkg::sum);
		next_cycle();
		register_comm(0, 8'd41, 6'b010010, coll_pkg::dir_root, coll_pkg::max);
		for (coll_pkg::seq_t r = 10'd1; r <= 10'd2; r++) begin
			for (int j = 0; j < 2; j++) begin
				a[j] = rand_payload();
				b[j] = rand_payload();
			end
			next_cycle();
			if (r == 10'd1) begin
				// Interleaved, 41 finishes first
				send(0, coll_pkg::xpos, coll_pkg::reduce, 8'd40, r, a[0]);
				send(0, coll_pkg::ypos, coll_pkg::reduce, 8'd41, r, b[0]);
				next_cycle();
				send(0, coll_pkg::yneg, coll_pkg::reduce, 8'd41, r, b[1]);
				expect_result(0, 6'b010010, cyc + lat_root, 8'd41, r,
					ref_reduce(coll_pkg::max, b, 2));
				next_cycle();
				send(0, coll_pkg::ypos, coll_pkg::reduce, 8'd40, r, a[1]);
				expect_result(0, 6'b000011, cyc + lat_root, 8'd40, r,
					ref_reduce(coll_pkg::sum, a, 2));
			end else begin
				send(0, coll_pkg::ypos, coll_pkg::reduce, 8'd40, r, a[0]);
				next_cycle();
				send(0, coll_pkg::ypos, coll_pkg::reduce, 8'd41, r, b[0]);
				next_cycle();
				// Both complete together; 40 holds the lower slot, 41 waits a cycle
				send(0, coll_pkg::xpos, coll_pkg::reduce, 8'd40, r, a[1]);
				send(0, coll_pkg::yneg, coll_pkg::reduce, 8'd41, r, b[1]);
				expect_result(0, 6'b000011, cyc + lat_root, 8'd40, r,
					ref_reduce(coll_pkg::sum, a, 2));
				expect_result(0, 6'b010010, cyc + lat_root + 1, 8'd41, r,
					ref_reduce(coll_pkg::max, b, 2));
			end
			wait_drain();
		end
	endtask

	task automatic test_filtering();
		coll_pkg::payload_t v [4];
		next_cycle();
		// Not a child, unknown comm, bcast off the parent port (twice)
		send(0, coll_pkg::xneg, coll_pkg::reduce, 8'd10, 10'd3, rand_payload());
		send(0, coll_pkg::xpos, coll_pkg::reduce, 8'd99, 10'd3, rand_payload());
		send(0, coll_pkg::ypos, coll_pkg::bcast, 8'd10, 10'd3, rand_payload());
		send(1, coll_pkg::xpos, coll_pkg::bcast, 8'd20, 10'd3, rand_payload());
		repeat (quiet_cycles) next_cycle();
		run_two_node(10'd4, 1'b1);
		// Comm 10 must still start from nothing
		v[0] = rand_payload();
		v[1] = rand_payload();
		send(0, coll_pkg::ypos, coll_pkg::reduce, 8'd10, 10'd5, v[0]);
		send(0, coll_pkg::xpos, coll_pkg::reduce, 8'd10, 10'd5, v[1]);
		expect_result(0, 6'b000011, cyc + lat_root, 8'd10, 10'd5,
			ref_reduce(coll_pkg::sum, v, 2));
		wait_drain();
	endtask

	task automatic test_reset_rereg();
		coll_pkg::payload_t v [4];
		next_cycle();
		send(0, coll_pkg::xpos, coll_pkg::reduce, 8'd10, 10'd6, rand_payload());
		// Partial of comm 10 lands in its slot before reset
		repeat (2) next_cycle();
		rst = 1'b1;
		repeat (2) next_cycle();
		rst = 1'b0;
		// Table is empty now, even a full instance goes nowhere
		send(0, coll_pkg::xpos, coll_pkg::reduce, 8'd10, 10'd6, rand_payload());
		send(0, coll_pkg::ypos, coll_pkg::reduce, 8'd10, 10'd6, rand_payload());
		repeat (quiet_cycles) next_cycle();
		register_comm(0, 8'd50, 6'b000011, coll_pkg::dir_root, coll_pkg::sum);
		next_cycle();
		send(0, coll_pkg::xpos, coll_pkg::reduce, 8'd50, 10'd7, rand_payload());
		repeat (3) next_cycle();
		// Overwrite with min, partial sum must vanish
		register_comm(0, 8'd50, 6'b000011, coll_pkg::dir_root, coll_pkg::min);
		repeat (2) next_cycle();
		v[0] = rand_payload();
		v[1] = rand_payload();
		send(0, coll_pkg::xpos, coll_pkg::reduce, 8'd50, 10'd8, v[0]);
		next_cycle();
		send(0, coll_pkg::ypos, coll_pkg::reduce, 8'd50, 10'd8, v[1]);
		expect_result(0, 6'b000011, cyc + lat_root, 8'd50, 10'd8,
			ref_reduce(coll_pkg::min, v, 2));
		wait_drain();
	endtask

	//////////////////////////////
	// Main sequence

	initial begin
		void'($urandom(38));
		rst = 1'b1;
		cyc = 0;
		for (int d = 0; d < `COLL_NUM_DIRS; d++) begin
			inj0[d] = '0;
			inj1[d] = '0;
		end
		nc0 = '0;
		nc1 = '0;
		repeat (2) @(posedge clk);
		next_cycle();
		rst = 1'b0;
		test_single_sum();
		next_cycle();
		register_comm(0, 8'd20, 6'b001100, coll_pkg::dir_root, coll_pkg::sum);
		register_comm(1, 8'd20, 6'b000001, coll_pkg::zneg, coll_pkg::sum);
		next_cycle();
		run_two_node(10'd2, 1'b0);
		test_operators();
		test_concurrent();
		test_filtering();
		test_reset_rereg();
		if (exp_port.size() != 0) begin
			$display("Run ended with %0d expected flits never seen", exp_port.size());
			$display("Some tests failed");
			$fatal(1, "expected output missing");
		end else begin
			$display("All tests passed");
			$finish;
		end
	end

	// Watchdog
	initial begin
		#(timeout_ns);
		$display("Timeout: the tests did not finish within %0d ns", timeout_ns);
		$display("Some tests failed");
		$fatal(1, "watchdog expired");
	end

endmodule
